/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Bus geometry
    localparam int data_width = 32;
    localparam int lane_count = 4;

    // Region codes compared against address bits 31..24
    localparam logic [7:0] region_ram = 8'h03;
    localparam logic [7:0] region_io  = 8'h04;

    // Work RAM
    localparam int ram_words       = 2048;
    localparam int ram_index_width = 11;    // Address bits 12..2

    // I/O block with slot i at I/O base + 4*i
    localparam int io_reg_count   = 8;
    localparam int io_index_width = 3;      // Address bits 4..2

    // Special slots among otherwise plain registers
    localparam int key_idx  = 0;            // Low half is the button state
    localparam int ie_idx   = 1;            // High half reads IF and writes acknowledge
    localparam int fifo_idx = 2;            // Sample queue push and head

    // Sample queue
    localparam int fifo_depth  = 8;
    localparam int level_width = 4;

    // Access size codes on bus_size
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

endpackage

`default_nettype wire

/* rtl/sample_fifo.sv */
`default_nettype none
`timescale 1ns/10ps

module sample_fifo (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              push,
    input  logic                              pop,
    input  logic                              clear,
    input  logic [mem_pkg::data_width-1:0]    push_data,
    output logic [mem_pkg::data_width-1:0]    head,
    output logic [mem_pkg::level_width-1:0]   level
);

    import mem_pkg::*;

    logic [data_width-1:0]         entries [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] put_ptr;
    logic [$clog2(fifo_depth)-1:0] get_ptr;
    logic                          do_push;
    logic                          do_pop;

    assign do_push = push && (level != fifo_depth);    // Full drops the sample
    assign do_pop  = pop && (level != 0);

    assign head = entries[get_ptr];

    always_ff @(posedge clock) begin
        if (do_push && !clear)
            entries[put_ptr] <= push_data;
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            put_ptr <= '0;
            get_ptr <= '0;
            level   <= '0;
        end else if (clear) begin
            put_ptr <= '0;
            get_ptr <= '0;
            level   <= '0;
        end else begin
            if (do_push) put_ptr <= put_ptr + 1'b1;
            if (do_pop)  get_ptr <= get_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/work_ram.sv */
`default_nettype none
`timescale 1ns/10ps

module work_ram (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [mem_pkg::ram_index_width-1:0]   mem_addr,
    input  logic [mem_pkg::lane_count-1:0]        ram_we,
    input  logic [mem_pkg::data_width-1:0]        wdata,
    output logic [mem_pkg::data_width-1:0]        ram_rdata
);

    import mem_pkg::*;

    logic [data_width-1:0] mem [ram_words];
    logic [data_width-1:0] merged;

    // Stored word with this cycle's lanes laid over it
    always_comb begin
        merged = mem[mem_addr];
        for (int i = 0; i < lane_count; i++) begin
            if (ram_we[i])
                merged[8*i +: 8] = wdata[8*i +: 8];
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < lane_count; i++) begin
            if (ram_we[i])
                mem[mem_addr][8*i +: 8] <= wdata[8*i +: 8];
        end
    end

    // Write-first read port
    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            ram_rdata <= '0;
        else
            ram_rdata <= merged;
    end

endmodule

`default_nettype wire

/* rtl/io_regs.sv */
`default_nettype none
`timescale 1ns/10ps

module io_regs (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [mem_pkg::io_index_width-1:0]    io_index,
    input  logic [mem_pkg::lane_count-1:0]        io_we,
    input  logic [mem_pkg::data_width-1:0]        wdata,
    input  logic [15:0]                           buttons,
    input  logic [15:0]                           reg_if,
    input  logic                                  sample_pop,
    input  logic                                  sample_clear,
    output logic [mem_pkg::data_width-1:0]        io_rdata,
    output logic [15:0]                           int_acks,
    output logic [mem_pkg::data_width-1:0]        sample_data,
    output logic [mem_pkg::level_width-1:0]       sample_level
);

    import mem_pkg::*;

    logic [data_width-1:0] gen_regs [io_reg_count];
    logic [15:0]           key_high;
    logic [15:0]           ie_low;
    logic                  gen_hit;
    logic                  key_hit;
    logic                  ie_hit;
    logic                  fifo_push;

    assign key_hit = (io_index == key_idx);
    assign ie_hit  = (io_index == ie_idx);
    assign gen_hit = !key_hit && !ie_hit && (io_index != fifo_idx);

    // Only lane 0 triggers a push of the whole word
    assign fifo_push = (io_index == fifo_idx) && io_we[0];

    // Plain byte-writable slots
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int s = 0; s < io_reg_count; s++)
                gen_regs[s] <= '0;
        end else if (gen_hit) begin
            for (int i = 0; i < lane_count; i++) begin
                if (io_we[i])
                    gen_regs[io_index][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Key high half, IE low half and the self-clearing acknowledge
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            key_high <= '0;
            ie_low   <= '0;
            int_acks <= '0;
        end else begin
            if (key_hit && io_we[2]) key_high[7:0]  <= wdata[23:16];
            if (key_hit && io_we[3]) key_high[15:8] <= wdata[31:24];
            if (ie_hit && io_we[0])  ie_low[7:0]    <= wdata[7:0];
            if (ie_hit && io_we[1])  ie_low[15:8]   <= wdata[15:8];
            // Held for one cycle only since the pause spacing rules out a second write
            int_acks[7:0]  <= (ie_hit && io_we[2]) ? wdata[23:16] : 8'h00;
            int_acks[15:8] <= (ie_hit && io_we[3]) ? wdata[31:24] : 8'h00;
        end
    end

    sample_fifo fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (fifo_push),
        .pop       (sample_pop),
        .clear     (sample_clear),
        .push_data (wdata),
        .head      (sample_data),
        .level     (sample_level)
    );

    always_comb begin
        case (io_index)
            key_idx:  io_rdata = {key_high, buttons};
            ie_idx:   io_rdata = {reg_if, ie_low};
            fifo_idx: io_rdata = sample_data;    // Queue head without a pop on read
            default:  io_rdata = gen_regs[io_index];
        endcase
    end

endmodule

`default_nettype wire

/* rtl/bus_port.sv */
`default_nettype none
`timescale 1ns/10ps

module bus_port (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [31:0]                           bus_addr,
    input  logic [mem_pkg::data_width-1:0]        bus_wdata,
    input  logic [1:0]                            bus_size,
    input  logic                                  bus_write,
    input  logic [mem_pkg::data_width-1:0]        ram_rdata,
    input  logic [mem_pkg::data_width-1:0]        io_rdata,
    output logic [mem_pkg::data_width-1:0]        bus_rdata,
    output logic                                  bus_pause,
    output logic [mem_pkg::ram_index_width-1:0]   mem_addr,
    output logic [mem_pkg::lane_count-1:0]        ram_we,
    output logic [mem_pkg::lane_count-1:0]        io_we,
    output logic [mem_pkg::io_index_width-1:0]    io_index,
    output logic [mem_pkg::data_width-1:0]        wdata
);

    import mem_pkg::*;

    logic [31:0]           addr_lat;
    logic [1:0]            size_lat;
    logic                  accept;
    logic                  commit;
    logic [lane_count-1:0] lanes;
    logic                  ram_sel;
    logic                  io_sel;

    // A write is taken only outside the pause, so one write gives one pause
    assign accept = bus_write & ~bus_pause;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            addr_lat  <= '0;
            size_lat  <= '0;
            bus_pause <= 1'b0;
        end else begin
            addr_lat  <= bus_addr;
            size_lat  <= bus_size;
            bus_pause <= accept;
        end
    end

    assign commit = bus_pause;    // Write lands at the end of the pause cycle

    // Byte lanes from the latched address and size
    always_comb begin
        case (size_lat)
            size_byte: lanes = lane_count'(1) << addr_lat[1:0];
            size_half: lanes = addr_lat[1] ? 4'b1100 : 4'b0011;
            size_word: lanes = '1;
            default:   lanes = '0;    // Code 3 touches nothing
        endcase
    end

    // Region decode on the latched address
    assign ram_sel = (addr_lat[31:24] == region_ram);
    assign io_sel  = (addr_lat[31:24] == region_io) && (addr_lat[23:2] < io_reg_count);

    assign ram_we = (commit && ram_sel) ? lanes : '0;
    assign io_we  = (commit && io_sel) ? lanes : '0;

    // Live address on reads lets the RAM start one cycle early
    assign mem_addr = commit ? addr_lat[ram_index_width+1:2]
                             : bus_addr[ram_index_width+1:2];
    assign io_index = addr_lat[io_index_width+1:2];

    // Master holds its data through the pause
    assign wdata = bus_wdata;

    // Read data follows the region of the address from the previous cycle
    always_comb begin
        if (ram_sel)
            bus_rdata = ram_rdata;
        else if (io_sel)
            bus_rdata = io_rdata;
        else
            bus_rdata = '0;    // Unmapped or beyond the last I/O slot
    end

endmodule

`default_nettype wire

/* rtl/mem_top.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_top (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [31:0]                       bus_addr,
    input  logic [mem_pkg::data_width-1:0]    bus_wdata,
    input  logic [1:0]                        bus_size,
    input  logic                              bus_write,
    output logic [mem_pkg::data_width-1:0]    bus_rdata,
    output logic                              bus_pause,
    input  logic [15:0]                       buttons,
    input  logic [15:0]                       reg_if,
    output logic [15:0]                       int_acks,
    input  logic                              sample_pop,
    input  logic                              sample_clear,
    output logic [mem_pkg::data_width-1:0]    sample_data,
    output logic [mem_pkg::level_width-1:0]   sample_level
);

    import mem_pkg::*;

    logic [ram_index_width-1:0] mem_addr;
    logic [lane_count-1:0]      ram_we;
    logic [lane_count-1:0]      io_we;
    logic [io_index_width-1:0]  io_index;
    logic [data_width-1:0]      wdata;
    logic [data_width-1:0]      ram_rdata;
    logic [data_width-1:0]      io_rdata;

    bus_port port (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .ram_rdata (ram_rdata),
        .io_rdata  (io_rdata),
        .bus_rdata (bus_rdata),
        .bus_pause (bus_pause),
        .mem_addr  (mem_addr),
        .ram_we    (ram_we),
        .io_we     (io_we),
        .io_index  (io_index),
        .wdata     (wdata)
    );

    work_ram wram (
        .clock     (clock),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .ram_we    (ram_we),
        .wdata     (wdata),
        .ram_rdata (ram_rdata)
    );

    io_regs io (
        .clock        (clock),
        .reset        (reset),
        .io_index     (io_index),
        .io_we        (io_we),
        .wdata        (wdata),
        .buttons      (buttons),
        .reg_if       (reg_if),
        .sample_pop   (sample_pop),
        .sample_clear (sample_clear),
        .io_rdata     (io_rdata),
        .int_acks     (int_acks),
        .sample_data  (sample_data),
        .sample_level (sample_level)
    );

endmodule

`default_nettype wire

/* sim/mem_top_sva.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_top_sva (
    input logic                            clock,
    input logic                            reset,
    input logic                            bus_write,
    input logic                            bus_pause,
    input logic [15:0]                     int_acks,
    input logic [mem_pkg::level_width-1:0] sample_level
);

    import mem_pkg::*;

    pause_after_write: assert property (@(posedge clock) disable iff (reset)
        bus_write && !bus_pause |=> bus_pause)
        else $error("bus_pause missing after an accepted write");

    pause_one_cycle: assert property (@(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause)
        else $error("bus_pause held longer than one cycle");

    // No pause without a write taken in the cycle before
    pause_needs_write: assert property (@(posedge clock) disable iff (reset)
        bus_pause |-> $past(bus_write && !bus_pause))
        else $error("bus_pause rose without an accepted write");

    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        int_acks != 16'h0000 |=> int_acks == 16'h0000)
        else $error("int_acks held for more than one cycle");

    level_in_range: assert property (@(posedge clock) disable iff (reset)
        sample_level <= fifo_depth)
        else $error("sample_level above the FIFO depth");

endmodule

bind mem_top mem_top_sva sva (
    .clock        (clock),
    .reset        (reset),
    .bus_write    (bus_write),
    .bus_pause    (bus_pause),
    .int_acks     (int_acks),
    .sample_level (sample_level)
);

`default_nettype wire

/* sim/mem_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_tb;

    import mem_pkg::*;

    localparam int period       = 4;
    localparam int ram_rounds   = 3;
    localparam int ram_ops      = 60;    // Writes then as many reads in each round
    localparam int io_ops       = 30;
    localparam int mix_ops      = 60;
    localparam int total_ops    = ram_rounds * 2 * ram_ops + 4 * 2 * io_ops + mix_ops;
    localparam int watch_cycles = total_ops * 3 + 10 + 200;

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [1:0]  bus_size;
    logic        bus_write;
    logic [31:0] bus_rdata;
    logic        bus_pause;
    logic [15:0] buttons;
    logic [15:0] reg_if;
    logic [15:0] int_acks;
    logic        sample_pop;
    logic        sample_clear;
    logic [31:0] sample_data;
    logic [level_width-1:0] sample_level;

    // Reference model
    logic [31:0] ram_model [int];
    int          ram_keys [$];
    logic [31:0] io_model [io_reg_count];
    logic [15:0] key_high;
    logic [15:0] ie_low;
    logic [31:0] sample_q [$];
    logic [31:0] rd_q [$];    // Addresses waiting for the next read burst
    int          checks;
    int          errors;
    int          last_checks;
    int          last_errors;

    mem_top UUT (
        .clock(clock), .reset(reset), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_size(bus_size), .bus_write(bus_write), .bus_rdata(bus_rdata),
        .bus_pause(bus_pause), .buttons(buttons), .reg_if(reg_if), .int_acks(int_acks),
        .sample_pop(sample_pop), .sample_clear(sample_clear), .sample_data(sample_data),
        .sample_level(sample_level)
    );

    always #(period / 2) clock = ~clock;

    function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] low);
        case (size)
            size_byte: return 4'b0001 << low;
            size_half: return low[1] ? 4'b1100 : 4'b0011;
            size_word: return 4'b1111;
            default:   return 4'b0000;
        endcase
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] mask);
        logic [31:0] word;
        word = old;
        for (int i = 0; i < 4; i++)
            if (mask[i])
                word[8*i +: 8] = data[8*i +: 8];
        return word;
    endfunction

    function automatic logic [31:0] ram_addr(input int idx, input logic [1:0] low);
        return {region_ram, 11'h000, 11'(idx), low};
    endfunction

    function automatic logic [31:0] io_addr(input int slot, input logic [1:0] low);
        return {region_io, 22'(slot), low};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [7:0] region;
        region = 8'($urandom);
        if (region == region_ram || region == region_io)
            region = 8'hfe;
        return {region, 24'($urandom)};
    endfunction

    function automatic logic [31:0] expect_read(input logic [31:0] addr);
        if (addr[31:24] == region_ram)
            return ram_model[int'(addr[12:2])];
        if (addr[31:24] != region_io || addr[23:2] >= io_reg_count)
            return '0;
        case (int'(addr[4:2]))
            key_idx:  return {key_high, buttons};    // Low half is the live button state
            ie_idx:   return {reg_if, ie_low};
            fifo_idx: return sample_q[0];
            default:  return io_model[addr[4:2]];
        endcase
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("** Error at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic check_state(input logic pause_exp, input logic [15:0] ack_exp);
        check(bus_pause === pause_exp,
              $sformatf("bus_pause %b, expected %b", bus_pause, pause_exp));
        check(int_acks === ack_exp,
              $sformatf("int_acks %h, expected %h", int_acks, ack_exp));
        check(sample_level === level_width'(sample_q.size()),
              $sformatf("sample_level %0d, expected %0d", sample_level, sample_q.size()));
        if (sample_q.size() > 0)
            check(sample_data === sample_q[0],
                  $sformatf("sample_data %h, expected %h", sample_data, sample_q[0]));
    endtask

    // Master holds everything through the pause and the write lands at its end
    task automatic write_op(input logic [31:0] addr, input logic [31:0] data,
                            input logic [1:0] size);
        logic [3:0]  mask;
        logic [15:0] ack;
        logic [31:0] word;
        int          idx;
        mask      = lane_mask(size, addr[1:0]);
        ack       = '0;
        bus_addr  = addr;
        bus_wdata = data;
        bus_size  = size;
        bus_write = 1'b1;
        @(posedge clock);
        #1;
        check_state(1'b1, '0);
        @(posedge clock);
        #1;
        if (addr[31:24] == region_ram) begin
            idx = int'(addr[12:2]);
            if (!ram_model.exists(idx)) begin
                ram_model[idx] = '0;    // First write to a word is always a full word
                ram_keys.push_back(idx);
            end
            ram_model[idx] = merge(ram_model[idx], data, mask);
        end else if (addr[31:24] == region_io && addr[23:2] < io_reg_count) begin
            case (int'(addr[4:2]))
                key_idx: begin
                    word     = merge({key_high, 16'h0000}, data, mask);
                    key_high = word[31:16];
                end
                ie_idx: begin
                    word   = merge({16'h0000, ie_low}, data, mask);
                    ie_low = word[15:0];
                    ack    = word[31:16];
                end
                fifo_idx: if (mask[0] && sample_q.size() < fifo_depth)
                    sample_q.push_back(data);
                default: io_model[addr[4:2]] = merge(io_model[addr[4:2]], data, mask);
            endcase
        end
        check_state(1'b0, ack);
        bus_write = 1'b0;
    endtask

    // One address per cycle with each checked in the cycle after it was presented
    task automatic run_reads();
        logic [31:0] cur;
        while (rd_q.size() > 0) begin
            cur      = rd_q.pop_front();
            bus_addr = cur;
            buttons  = 16'($urandom);
            reg_if   = 16'($urandom);
            @(posedge clock);
            #1;
            check(bus_rdata === expect_read(cur),
                  $sformatf("read %h gave %h, expected %h", cur, bus_rdata, expect_read(cur)));
            check_state(1'b0, '0);
        end
    endtask

    task automatic audio_op(input bit clear);
        sample_pop   = !clear;
        sample_clear = clear;
        @(posedge clock);
        #1;
        sample_pop   = 1'b0;
        sample_clear = 1'b0;
        if (clear)
            sample_q.delete();
        else if (sample_q.size() > 0)
            void'(sample_q.pop_front());    // Pop on empty does nothing
        check_state(1'b0, '0);
    endtask

    task automatic slot_rounds(input int slot);
        for (int i = 0; i < io_ops; i++) begin
            write_op(io_addr(slot, 2'($urandom)), $urandom, 2'($urandom % 3));
            rd_q.push_back(io_addr(slot, 2'b00));
            rd_q.push_back(io_addr(slot, 2'b00));
            run_reads();
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    initial begin
        #(watch_cycles * period);
        $display("Watchdog expired after %0d cycles, the run did not finish", watch_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int          idx;
        int          n;
        logic [1:0]  size;
        logic [31:0] addr;
        n = $urandom(32'heea);
        checks      = 0;
        errors      = 0;
        last_checks = 0;
        last_errors = 0;
        foreach (io_model[s])
            io_model[s] = '0;
        key_high     = '0;
        ie_low       = '0;
        reset        = 1'b1;
        bus_addr     = '0;
        bus_wdata    = '0;
        bus_size     = size_word;
        bus_write    = 1'b0;
        buttons      = '0;
        reg_if       = '0;
        sample_pop   = 1'b0;
        sample_clear = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int r = 0; r < ram_rounds; r++) begin
            for (int i = 0; i < ram_ops; i++) begin
                idx  = $urandom % 64;
                size = ram_model.exists(idx) ? 2'($urandom % 4) : size_word;
                write_op(ram_addr(idx, 2'($urandom)), $urandom, size);
            end
            for (int i = 0; i < ram_ops; i++)
                rd_q.push_back(ram_addr(ram_keys[$urandom % ram_keys.size()], 2'($urandom)));
            run_reads();
        end
        end_test("work RAM lanes and pipelined reads");

        for (int i = 0; i < io_ops; i++) begin
            n = $urandom % 3;
            if (n == 0)
                addr = io_addr(3 + $urandom % 5, 2'($urandom));
            else if (n == 1)
                addr = {region_io, 22'(io_reg_count + $urandom % 4096), 2'($urandom)};
            else
                addr = unmapped_addr();
            write_op(addr, $urandom, 2'($urandom % 3));
        end
        for (int s = 3; s < io_reg_count; s++)
            rd_q.push_back(io_addr(s, 2'b00));
        for (int i = 0; i < 5; i++) begin
            rd_q.push_back({region_io, 22'(io_reg_count + $urandom % 4096), 2'b00});
            rd_q.push_back(unmapped_addr());
        end
        run_reads();
        end_test("general I/O slots and unmapped reads");

        slot_rounds(key_idx);
        end_test("key register");
        slot_rounds(ie_idx);
        end_test("interrupt enable and acknowledge");

        for (int i = 0; i < io_ops; i++) begin
            n = $urandom % 8;
            if (n < 5) begin
                write_op(io_addr(fifo_idx, 2'($urandom)), $urandom, 2'($urandom % 3));
            end else if (n < 7) begin
                audio_op(1'b0);
            end else if (sample_q.size() > 0) begin
                rd_q.push_back(io_addr(fifo_idx, 2'b00));
                run_reads();
            end
        end
        for (int i = 0; i < 12; i++)
            write_op(io_addr(fifo_idx, 2'b00), $urandom, size_word);    // Last ones drop
        audio_op(1'b1);
        audio_op(1'b0);
        end_test("sample FIFO");

        for (int i = 0; i < mix_ops; i++) begin
            idx = ram_keys[$urandom % ram_keys.size()];
            if ($urandom % 2) begin
                write_op(ram_addr(idx, 2'($urandom)), $urandom, 2'($urandom % 4));
            end else begin
                rd_q.push_back(ram_addr(idx, 2'b00));
                run_reads();
            end
        end
        end_test("write pause");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/mem_pkg.sv
rtl/sample_fifo.sv
rtl/work_ram.sv
rtl/io_regs.sv
rtl/bus_port.sv
rtl/mem_top.sv
sim/mem_top_sva.sv
sim/mem_tb.sv
